// File: files.f
+incdir+.
gfx_pkg.sv
gfx_cmd_fsm.sv
word_counter.sv
vram_writer.sv
gfx_top.sv
gfx_assert.sv
tb_gfx.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_gfx -f files.f -o sim_gfx > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_gfx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
exit 1

// File: tb_gfx.sv
// ********************************************************************
// testbench of the frame-buffer front end with directed and random
// commands checked against a reference model and a memory that acks late
// ********************************************************************

`timescale 1ns/1ps
`include "gfx_cfg.svh"

module tb_gfx
    import gfx_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int MIX_CMDS        = 60;
    localparam int MAX_CMDS        = 100;
    localparam int WATCHDOG_CYCLES = MAX_CMDS * `GFX_FB_WORDS * 5;

    logic        clk;
    logic        reset_i;
    logic        cmd_valid_i;
    logic        cmd_ready_o;
    gfx_cmd_t    cmd_data_i;
    logic        vram_req_o;
    vram_req_t   vram_o;
    logic        vram_ack_i;
    logic        vsync_i;
    logic        swap_o;
    logic [31:0] front_addr_o;

    logic [15:0] mem_model [logic [31:0]];
    logic [15:0] ref_mem [logic [31:0]];
    vram_req_t   wr_log [$];
    logic [31:0] ref_front;
    logic [31:0] ref_back;
    logic [31:0] ref_tex;
    logic        vsync_auto;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_errors = 0;
    int          swap_count = 0;

    gfx_top dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_data_i   (cmd_data_i),
        .vram_req_o   (vram_req_o),
        .vram_o       (vram_o),
        .vram_ack_i   (vram_ack_i),
        .vsync_i      (vsync_i),
        .swap_o       (swap_o),
        .front_addr_o (front_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ****************************************************************
    // memory model that acks each request after 0 to 3 cycles
    // ****************************************************************

    initial begin
        int unsigned ack_wait;
        logic        busy;
        vram_ack_i = 1'b0;
        busy       = 1'b0;
        ack_wait   = 0;
        forever begin
            @(negedge clk);
            if (vram_ack_i) begin
                vram_ack_i = 1'b0;
                busy       = 1'b0;
            end else if (vram_req_o) begin
                if (!busy) begin
                    busy     = 1'b1;
                    ack_wait = $urandom_range(3, 0);
                end
                // the write completes on the next rising edge
                if (ack_wait == 0) begin
                    vram_ack_i = 1'b1;
                    mem_model[vram_o.addr] = vram_o.data;
                    wr_log.push_back(vram_o);
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (swap_o === 1'b1) begin
            swap_count++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, a command never completed",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    function automatic gfx_cmd_t make_clear(input logic depth, input logic [15:0] fill);
        gfx_cmd_t c;
        c            = '0;
        c.clr.opcode = `GFX_OP_CLEAR;
        c.clr.depth  = depth;
        c.clr.fill   = fill;
        return c;
    endfunction

    function automatic gfx_cmd_t make_imm(input gfx_op_t op, input logic high,
                                          input logic [15:0] value);
        gfx_cmd_t c;
        c            = '0;
        c.imm.opcode = op;
        c.imm.high   = high;
        c.imm.value  = value;
        return c;
    endfunction

    function automatic gfx_cmd_t make_swap(input logic wait_vsync);
        gfx_cmd_t c;
        c                = '0;
        c.swp.opcode     = `GFX_OP_SWAP;
        c.swp.wait_vsync = wait_vsync;
        return c;
    endfunction

    function automatic gfx_cmd_t make_unknown();
        gfx_cmd_t c;
        c = $urandom();
        while (c.imm.opcode inside {`GFX_OP_CLEAR, `GFX_OP_SWAP,
                                    `GFX_OP_SET_TEX_ADDR, `GFX_OP_WRITE_TEX}) begin
            c.imm.opcode = 8'($urandom_range(255, 0));
        end
        return c;
    endfunction

    // reference model of the command rules
    task automatic apply_ref(input gfx_cmd_t c);
        logic [31:0] base;
        logic [31:0] tmp;
        case (c.imm.opcode)
            `GFX_OP_CLEAR: begin
                base = c.clr.depth ? `GFX_DEPTH_BASE : ref_back;
                for (int i = 0; i < `GFX_FB_WORDS; i++) begin
                    ref_mem[base + 32'(i)] = c.clr.fill;
                end
            end
            `GFX_OP_SWAP: begin
                tmp       = ref_front;
                ref_front = ref_back;
                ref_back  = tmp;
            end
            `GFX_OP_SET_TEX_ADDR: begin
                if (c.imm.high) begin
                    ref_tex[31:16] = c.imm.value;
                end else begin
                    ref_tex[15:0] = c.imm.value;
                end
            end
            `GFX_OP_WRITE_TEX: begin
                ref_mem[ref_tex] = c.imm.value;
                ref_tex          = ref_tex + 32'd1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic wait_ready();
        while (!cmd_ready_o) begin
            @(negedge clk);
            if (vsync_auto) begin
                vsync_i = ($urandom_range(3, 0) == 0);
            end
        end
    endtask

    task automatic send_cmd(input gfx_cmd_t c);
        wait_ready();
        wr_log.delete();
        cmd_valid_i = 1'b1;
        cmd_data_i  = c;
        @(negedge clk);
        cmd_valid_i = 1'b0;
        cmd_data_i  = $urandom();
        apply_ref(c);
    endtask

    task automatic run_cmd(input gfx_cmd_t c);
        send_cmd(c);
        wait_ready();
        @(negedge clk);
        check_value("front_addr_o", front_addr_o, ref_front);
    endtask

    // the writes of the last command must be count words in address order
    task automatic check_run(input logic [31:0] base, input int count, input logic [15:0] fill);
        check_value("write count", 32'(wr_log.size()), 32'(count));
        foreach (wr_log[i]) begin
            check_value($sformatf("vram_o.addr (write %0d)", i), wr_log[i].addr, base + 32'(i));
            check_value($sformatf("vram_o.data (write %0d)", i), 32'(wr_log[i].data), 32'(fill));
        end
    endtask

    task automatic compare_memories();
        check_value("memory word count", 32'(mem_model.num()), 32'(ref_mem.num()));
        foreach (ref_mem[a]) begin
            if (!mem_model.exists(a)) begin
                errors++;
                $display("no write reached address %h, the reference holds %h there",
                         a, ref_mem[a]);
            end else begin
                check_value($sformatf("vram word %h", a), 32'(mem_model[a]), 32'(ref_mem[a]));
            end
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == test_errors) ? "ok" : "failed");
        test_errors = errors;
    endtask

    // ****************************************************************
    // test sequence
    // ****************************************************************

    initial begin
        logic [15:0] colour;
        logic [15:0] word;
        logic [31:0] tex_set;
        logic [31:0] old_front;
        int          start_swaps;
        int          n_tex;
        int          kind;
        void'($urandom(32'h6a35a3ce));
        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_data_i  = '0;
        vsync_i     = 1'b0;
        vsync_auto  = 1'b0;
        ref_front   = `GFX_FRONT_BASE;
        ref_back    = `GFX_BACK_BASE;
        ref_tex     = `GFX_TEX_BASE;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        check_value("front_addr_o", front_addr_o, `GFX_FRONT_BASE);
        check_value("cmd_ready_o", 32'(cmd_ready_o), 32'd1);
        check_value("vram_req_o", 32'(vram_req_o), 32'd0);
        check_value("swap_o", 32'(swap_o), 32'd0);
        colour = 16'($urandom());
        run_cmd(make_clear(1'b0, colour));
        check_run(`GFX_BACK_BASE, `GFX_FB_WORDS, colour);
        compare_memories();
        end_test("reset and colour clear");

        colour = 16'($urandom());
        run_cmd(make_clear(1'b1, colour));
        check_run(`GFX_DEPTH_BASE, `GFX_FB_WORDS, colour);
        compare_memories();
        end_test("depth clear");

        tex_set = $urandom();
        run_cmd(make_imm(`GFX_OP_SET_TEX_ADDR, 1'b1, tex_set[31:16]));
        run_cmd(make_imm(`GFX_OP_SET_TEX_ADDR, 1'b0, tex_set[15:0]));
        n_tex = $urandom_range(12, 4);
        for (int i = 0; i < n_tex; i++) begin
            word = 16'($urandom());
            run_cmd(make_imm(`GFX_OP_WRITE_TEX, 1'b0, word));
            check_run(tex_set + 32'(i), 1, word);
        end
        compare_memories();
        end_test("texture address and writes");

        old_front   = ref_front;
        start_swaps = swap_count;
        run_cmd(make_swap(1'b0));
        check_value("swap_o pulses", 32'(swap_count - start_swaps), 32'd1);
        colour = 16'($urandom());
        run_cmd(make_clear(1'b0, colour));
        check_run(old_front, `GFX_FB_WORDS, colour);
        compare_memories();
        end_test("immediate swap");

        old_front   = ref_front;
        start_swaps = swap_count;
        send_cmd(make_swap(1'b1));
        repeat (10) begin
            @(negedge clk);
            check_value("cmd_ready_o", 32'(cmd_ready_o), 32'd0);
            check_value("front_addr_o", front_addr_o, old_front);
        end
        check_value("swap_o pulses", 32'(swap_count - start_swaps), 32'd0);
        vsync_i = 1'b1;
        wait_ready();
        vsync_i = 1'b0;
        @(negedge clk);
        check_value("swap_o pulses", 32'(swap_count - start_swaps), 32'd1);
        check_value("front_addr_o", front_addr_o, ref_front);
        // an unknown opcode spends one cycle in DECODE and is back in IDLE
        repeat (3) begin
            send_cmd(make_unknown());
            @(negedge clk);
            check_value("cmd_ready_o", 32'(cmd_ready_o), 32'd1);
            wait_ready();
            @(negedge clk);
            check_run(32'd0, 0, 16'd0);
            check_value("front_addr_o", front_addr_o, ref_front);
        end
        compare_memories();
        end_test("vsync swap and unknown opcodes");

        vsync_auto = 1'b1;
        repeat (MIX_CMDS) begin
            kind = $urandom_range(7, 0);
            case (kind)
                0, 1: run_cmd(make_clear(kind[0], 16'($urandom())));
                2, 3: run_cmd(make_imm(`GFX_OP_SET_TEX_ADDR, kind[0], 16'($urandom())));
                4, 5: run_cmd(make_imm(`GFX_OP_WRITE_TEX, 1'b0, 16'($urandom())));
                6: run_cmd(make_swap(1'($urandom())));
                default: run_cmd(make_unknown());
            endcase
        end
        vsync_auto = 1'b0;
        vsync_i    = 1'b0;
        compare_memories();
        end_test("random command mix");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: gfx_assert.sv
// ********************************************************************
// handshake assertions for the frame-buffer front end, bound into
// the top level so that they watch every simulation of it
// ********************************************************************

`timescale 1ns/1ps

module gfx_assert
    import gfx_pkg::*;
(
    input logic      clk,
    input logic      reset_i,
    input logic      cmd_ready_i,
    input logic      vram_req_i,
    input vram_req_t vram_i,
    input logic      vram_ack_i,
    input logic      swap_i
);

    // a request waiting for its ack keeps address and data
    a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
        (vram_req_i && !vram_ack_i) |=> (vram_req_i && $stable(vram_i)))
        else $error("memory request changed before it was acknowledged");

    a_swap_single: assert property (@(posedge clk) disable iff (reset_i)
        swap_i |=> !swap_i)
        else $error("swap pulse lasted more than one cycle");

    // no new command is taken while a write is in flight
    a_ready_low: assert property (@(posedge clk) disable iff (reset_i)
        vram_req_i |-> !cmd_ready_i)
        else $error("command ready was high with a memory request pending");

endmodule

bind gfx_top gfx_assert u_assert (
    .clk         (clk),
    .reset_i     (reset_i),
    .cmd_ready_i (cmd_ready_o),
    .vram_req_i  (vram_req_o),
    .vram_i      (vram_o),
    .vram_ack_i  (vram_ack_i),
    .swap_i      (swap_o)
);

// File: gfx_top.sv
// ********************************************************************
// frame-buffer front end top level
// command stream in, one memory write port out, plus buffer swap
// ********************************************************************

`timescale 1ns/1ps

module gfx_top
    import gfx_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,

    input  logic        cmd_valid_i,
    output logic        cmd_ready_o,
    input  gfx_cmd_t    cmd_data_i,

    output logic        vram_req_o,
    output vram_req_t   vram_o,
    input  logic        vram_ack_i,

    input  logic        vsync_i,
    output logic        swap_o,
    output logic [31:0] front_addr_o
);

    logic        wr_start;
    vram_req_t   wr_req;
    logic        wr_done;
    logic        cnt_load;
    logic [31:0] cnt_base;
    logic [31:0] cnt_addr;
    logic        cnt_last;

    gfx_cmd_fsm u_fsm (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_data_i   (cmd_data_i),
        .vsync_i      (vsync_i),
        .swap_o       (swap_o),
        .front_addr_o (front_addr_o),
        .wr_start_o   (wr_start),
        .wr_req_o     (wr_req),
        .wr_done_i    (wr_done),
        .cnt_load_o   (cnt_load),
        .cnt_base_o   (cnt_base),
        .cnt_addr_i   (cnt_addr),
        .cnt_last_i   (cnt_last)
    );

    word_counter u_counter (
        .clk     (clk),
        .reset_i (reset_i),
        .load_i  (cnt_load),
        .base_i  (cnt_base),
        .step_i  (wr_done),
        .addr_o  (cnt_addr),
        .last_o  (cnt_last)
    );

    vram_writer u_writer (
        .clk        (clk),
        .reset_i    (reset_i),
        .start_i    (wr_start),
        .req_i      (wr_req),
        .vram_ack_i (vram_ack_i),
        .vram_req_o (vram_req_o),
        .vram_o     (vram_o),
        .done_o     (wr_done)
    );

endmodule

// File: vram_writer.sv
// ********************************************************************
// memory write port register
// captures a request on start and holds it until the memory acks
// ********************************************************************

`timescale 1ns/1ps

module vram_writer
    import gfx_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      start_i,
    input  vram_req_t req_i,
    input  logic      vram_ack_i,
    output logic      vram_req_o,
    output vram_req_t vram_o,
    output logic      done_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_req_o <= 1'b0;
        end else if (!vram_req_o) begin
            vram_req_o <= start_i;
        end else if (vram_ack_i) begin
            vram_req_o <= 1'b0;
        end
    end

    // a start during a pending request is ignored so the port stays stable
    always_ff @(posedge clk) begin
        if (start_i && !vram_req_o) begin
            vram_o <= req_i;
        end
    end

    // the request drops on the ack edge, so this is a single cycle
    assign done_o = vram_req_o & vram_ack_i;

endmodule

// File: word_counter.sv
// ********************************************************************
// address counter for clear runs over one full frame
// load sets the start, each completed write steps to the next word
// ********************************************************************

`timescale 1ns/1ps
`include "gfx_cfg.svh"

module word_counter (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        load_i,
    input  logic [31:0] base_i,
    input  logic        step_i,
    output logic [31:0] addr_o,
    output logic        last_o
);

    logic [31:0] end_addr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr_o   <= 32'd0;
            end_addr <= 32'(`GFX_FB_WORDS - 1);
        end else if (load_i) begin
            addr_o   <= base_i;
            end_addr <= base_i + 32'(`GFX_FB_WORDS) - 32'd1;
        end else if (step_i) begin
            addr_o <= addr_o + 32'd1;
        end
    end

    // high while the word being written is the final one of the run
    assign last_o = (addr_o == end_addr);

endmodule

// File: gfx_cmd_fsm.sv
// ********************************************************************
// command FSM of the frame-buffer front end
// takes one word per handshake, decodes it and drives the address
// counter and the memory writer until the command has completed
// ********************************************************************

`timescale 1ns/1ps
`include "gfx_cfg.svh"

module gfx_cmd_fsm
    import gfx_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,

    input  logic        cmd_valid_i,
    output logic        cmd_ready_o,
    input  gfx_cmd_t    cmd_data_i,

    input  logic        vsync_i,
    output logic        swap_o,
    output logic [31:0] front_addr_o,

    output logic        wr_start_o,
    output vram_req_t   wr_req_o,
    input  logic        wr_done_i,

    output logic        cnt_load_o,
    output logic [31:0] cnt_base_o,
    input  logic [31:0] cnt_addr_i,
    input  logic        cnt_last_i
);

    gfx_state_t  state;
    gfx_cmd_t    cmd_q;
    gfx_op_t     op;
    logic [31:0] back_addr;
    logic [31:0] tex_addr;
    logic        issue_q;
    logic        swap_now;

    assign op          = cmd_q.imm.opcode;
    assign cmd_ready_o = (state == IDLE);

    // buffers exchange at once unless the command asks to wait for vsync
    assign swap_now = ((state == DECODE) && (op == `GFX_OP_SWAP) &&
                       (!cmd_q.swp.wait_vsync || vsync_i)) ||
                      ((state == SWAP_WAIT) && vsync_i);

    always_ff @(posedge clk) begin
        if (cmd_ready_o && cmd_valid_i) begin
            cmd_q <= cmd_data_i;
        end
    end

    // ****************************************************************
    // sequencing
    // ****************************************************************

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= IDLE;
            front_addr_o <= `GFX_FRONT_BASE;
            back_addr    <= `GFX_BACK_BASE;
            tex_addr     <= `GFX_TEX_BASE;
            swap_o       <= 1'b0;
            issue_q      <= 1'b0;
        end else begin
            swap_o  <= swap_now;
            issue_q <= 1'b0;

            if (swap_now) begin
                front_addr_o <= back_addr;
                back_addr    <= front_addr_o;
            end

            case (state)
                IDLE: begin
                    if (cmd_valid_i) begin
                        state <= DECODE;
                    end
                end

                DECODE: begin
                    case (op)
                        `GFX_OP_CLEAR: begin
                            issue_q <= 1'b1;
                            state   <= CLEAR_RUN;
                        end
                        `GFX_OP_SWAP: begin
                            state <= swap_now ? IDLE : SWAP_WAIT;
                        end
                        `GFX_OP_SET_TEX_ADDR: begin
                            if (cmd_q.imm.high) begin
                                tex_addr[31:16] <= cmd_q.imm.value;
                            end else begin
                                tex_addr[15:0] <= cmd_q.imm.value;
                            end
                            state <= IDLE;
                        end
                        `GFX_OP_WRITE_TEX: begin
                            state <= TEX_WRITE;
                        end
                        default: begin
                            state <= IDLE;
                        end
                    endcase
                end

                // the counter has stepped by the time the next write issues
                CLEAR_RUN: begin
                    if (wr_done_i) begin
                        if (cnt_last_i) begin
                            state <= IDLE;
                        end else begin
                            issue_q <= 1'b1;
                        end
                    end
                end

                TEX_WRITE: begin
                    if (wr_done_i) begin
                        tex_addr <= tex_addr + 32'd1;
                        state    <= IDLE;
                    end
                end

                SWAP_WAIT: begin
                    if (vsync_i) begin
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // clear writes come from the counter, a texture write from tex_addr
    always_comb begin
        cnt_load_o    = (state == DECODE) && (op == `GFX_OP_CLEAR);
        cnt_base_o    = cmd_q.clr.depth ? `GFX_DEPTH_BASE : back_addr;
        wr_start_o    = issue_q;
        wr_req_o.addr = cnt_addr_i;
        // the clear and immediate views keep the write data in the same low half
        wr_req_o.data = cmd_q.clr.fill;
        if ((state == DECODE) && (op == `GFX_OP_WRITE_TEX)) begin
            wr_start_o    = 1'b1;
            wr_req_o.addr = tex_addr;
        end
    end

endmodule

// File: gfx_pkg.sv
// ********************************************************************
// types shared by the frame-buffer front end and its testbench
// command word views, memory write request and FSM states
// ********************************************************************

`include "gfx_cfg.svh"

package gfx_pkg;

    typedef logic [31-`GFX_OP_POS:0] gfx_op_t;

    // immediate operand, used to load a 32-bit register by halves
    typedef struct packed {
        gfx_op_t                 opcode;
        logic [`GFX_OP_POS-18:0] rsvd;
        logic                    high;
        logic [15:0]             value;
    } gfx_imm_t;

    // clear operand, selects the colour or depth buffer
    typedef struct packed {
        gfx_op_t                 opcode;
        logic [`GFX_OP_POS-18:0] rsvd;
        logic                    depth;
        logic [15:0]             fill;
    } gfx_clear_t;

    typedef struct packed {
        gfx_op_t                 opcode;
        logic [`GFX_OP_POS-2:0]  rsvd;
        logic                    wait_vsync;
    } gfx_swap_t;

    // one command word, read through the view that its opcode selects
    typedef union packed {
        gfx_imm_t   imm;
        gfx_clear_t clr;
        gfx_swap_t  swp;
    } gfx_cmd_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [15:0] data;
    } vram_req_t;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        CLEAR_RUN,
        TEX_WRITE,
        SWAP_WAIT
    } gfx_state_t;

endpackage

// File: gfx_cfg.svh
// ********************************************************************
// frame size, memory layout and command opcodes of the frame-buffer
// front end, shared by the RTL and the testbench through `include
// ********************************************************************

`ifndef GFX_CFG_SVH
`define GFX_CFG_SVH

`define GFX_FB_WIDTH   16
`define GFX_FB_HEIGHT  16
`define GFX_FB_WORDS   (`GFX_FB_WIDTH * `GFX_FB_HEIGHT)

// buffers sit back to back in word addresses
`define GFX_FRONT_BASE (32'd0)
`define GFX_BACK_BASE  (32'(`GFX_FB_WORDS))
`define GFX_DEPTH_BASE (32'(2 * `GFX_FB_WORDS))
`define GFX_TEX_BASE   (32'(3 * `GFX_FB_WORDS))

`define GFX_OP_CLEAR        8'd21
`define GFX_OP_SWAP         8'd23
`define GFX_OP_SET_TEX_ADDR 8'd24
`define GFX_OP_WRITE_TEX    8'd25

// opcode occupies the command word from this bit up to bit 31
`define GFX_OP_POS 24

`endif
